/* hdl/synth_settings.svh */
// synth settings
// widths, frame timing and oscillator constants shared by the audio path

`ifndef SYNTH_SETTINGS_SVH
`define SYNTH_SETTINGS_SVH

// --------------------
// data widths
`define SAMPLE_W      16          // audio word
`define PHASE_W       32          // voice phase accumulator
`define SAW_BITS      13          // phase msbs each voice adds to the mix

// --------------------
// channel map
`define NUM_CH        8           // ad7606 channels
`define NUM_VOICES    8           // supersaw voices
`define PITCH_CH      4           // channel 5 sets the pitch
`define MONITOR_CH    0           // channel 1 goes to the right dac side
`define ADC_OFFSET    16'h8000    // two's complement -> offset binary

// --------------------
// frame timing, both frames share one length
`define FRAME_CLKS    512         // clk per adc frame and per i2s frame
`define ADC_STEP_DIV  2           // clk per adc step
`define I2S_TICK_DIV  8           // clk per i2s word tick

// --------------------
// oscillator
`define PITCH_SHIFT   8           // pitch -> phase increment
`define DETUNE_0      32'd78855
`define DETUNE_1      32'd98851
`define DETUNE_2      32'd118853
`define DETUNE_3      32'd138857
`define DETUNE_4      32'd148853
`define DETUNE_5      32'd158855
`define DETUNE_6      32'd168857
`define DETUNE_7      32'd178851

`endif

/* hdl/synth_pkg.sv */
// synth types
// sample, phase and adc step types used across the audio path

`include "synth_settings.svh"

package synth_pkg;

	// --------------------
	// audio data

	// offset binary audio word, 0x8000 is mid scale
	typedef logic [`SAMPLE_W-1:0] sample_t;

	// saw phase, wraps modulo 2^32
	typedef logic [`PHASE_W-1:0] phase_t;

	// --------------------
	// adc frame control

	// step index inside one adc frame
	//   0..127   read phase, four groups of 32 steps
	//   128..255 cs high, conversion at step 129
	typedef logic [7:0] adc_step_t;

endpackage

/* hdl/ad7606_reader.sv */
// AD7606 serial reader
// runs the frame step counter, drives rdclk, conv and cs, shifts in
// channels 1-4 from db7 and 5-8 from db8, publishes them in offset binary

`include "synth_settings.svh"

module ad7606_reader (
	input  logic               clk,
	input  logic               trigger,
	input  logic               db7,                  // serial data ch 1-4
	input  logic               db8,                  // serial data ch 5-8
	output logic               rdclk,                // serial data clock
	output logic               conv,                 // conversion start, active low
	output logic               cs,                   // chip select
	output synth_pkg::sample_t channels [`NUM_CH]    // offset binary samples
);
	import synth_pkg::*;

	localparam int STEPS      = `FRAME_CLKS / `ADC_STEP_DIV;  // 256
	localparam int READ_STEPS = STEPS / 2;                     // steps 0..127 read
	localparam int CONV_STEP  = READ_STEPS + 1;                // conv low here
	localparam int LANES      = `NUM_CH / 2;                   // channels per data line
	localparam int DIV_W      = $clog2(`ADC_STEP_DIV);

	// --------------------
	// step counter

	logic [DIV_W-1:0] div;         // clk -> step divider
	logic             step_adv;    // last clk of the current step
	adc_step_t        step;        // current step in frame
	adc_step_t        step_nxt;    // step after this edge

	assign step_adv = (div == DIV_W'(`ADC_STEP_DIV - 1));
	assign step_nxt = step_adv ? adc_step_t'(step + 8'd1) : step;

	// control outputs for the step that is in effect after the edge
	logic       nxt_read;
	logic [3:0] nxt_slot;          // bit slot inside a 32 step group
	logic       rdclk_nxt;
	logic       conv_nxt;
	logic       cs_nxt;

	always_comb begin
		nxt_read  = (step_nxt < READ_STEPS);
		nxt_slot  = step_nxt[4:1];
		// low on even steps, last two bits of a group stay high
		rdclk_nxt = !(nxt_read && !step_nxt[0] && (nxt_slot < 4'(`SAMPLE_W - 2)));
		conv_nxt  = (step_nxt != adc_step_t'(CONV_STEP));
		cs_nxt    = !nxt_read;     // idle half of the frame
	end

	always_ff @(posedge clk or posedge trigger) begin
		if (trigger) begin
			div   <= '0;
			step  <= '0;
			rdclk <= 1'b1;
			conv  <= 1'b1;
			cs    <= 1'b0;
		end else begin
			div   <= step_adv ? '0 : DIV_W'(div + 1'b1);
			step  <= step_nxt;     // wraps at 256, frame restart
			rdclk <= rdclk_nxt;
			conv  <= conv_nxt;
			cs    <= cs_nxt;
		end
	end

	// --------------------
	// serial capture

	sample_t    raw [`NUM_CH];     // two's complement shift registers
	logic [1:0] grp;               // group = channel pair in flight
	logic       bit_sample;

	assign grp = step[6:5];
	// bit held over steps 2b and 2b+1, taken at the end of step 2b
	assign bit_sample = step_adv && (step < READ_STEPS) && !step[0];

	always_ff @(posedge clk) begin
		if (bit_sample) begin
			// msb first, 16 shifts fill a word
			raw[grp]         <= {raw[grp][`SAMPLE_W-2:0], db7};
			raw[grp + LANES] <= {raw[grp + LANES][`SAMPLE_W-2:0], db8};
		end
	end

	// --------------------
	// publish at the start of step 128

	logic publish;

	assign publish = step_adv && (step == adc_step_t'(READ_STEPS - 1));

	always_ff @(posedge clk or posedge trigger) begin
		if (trigger) begin
			for (int i = 0; i < `NUM_CH; i++) begin
				channels[i] <= '0;
			end
		end else if (publish) begin
			for (int i = 0; i < `NUM_CH; i++) begin
				channels[i] <= sample_t'(raw[i] + `ADC_OFFSET);  // mod 2^16
			end
		end
	end

endmodule

/* hdl/saw_voice.sv */
// saw voice
// one detuned phase accumulator, advanced once per audio sample

`include "synth_settings.svh"

module saw_voice #(
	parameter synth_pkg::phase_t detune = '0    // per voice spread
) (
	input  logic               clk,
	input  logic               trigger,
	input  logic               sample_strobe,   // one clk per i2s frame
	input  synth_pkg::sample_t pitch,           // offset binary pitch cv
	output synth_pkg::phase_t  phase
);
	import synth_pkg::*;

	phase_t step_inc;    // phase increment per sample

	// pitch scaled up, detune on top
	assign step_inc = phase_t'((phase_t'(pitch) << `PITCH_SHIFT) + detune);

	always_ff @(posedge clk or posedge trigger) begin
		if (trigger) begin
			phase <= '0;
		end else if (sample_strobe) begin
			phase <= phase_t'(phase + step_inc);    // wraps, saw reset
		end
	end

endmodule

/* hdl/voice_mixer.sv */
// voice mixer
// adds the top phase bits of all voices in a small tree, registered each clk

`include "synth_settings.svh"

module voice_mixer (
	input  logic               clk,
	input  logic               trigger,
	input  synth_pkg::phase_t  phases [`NUM_VOICES],
	output synth_pkg::sample_t mix
);
	import synth_pkg::*;

	localparam int SW = `SAW_BITS;

	logic [SW-1:0] saw  [`NUM_VOICES];        // one saw per voice
	logic [SW:0]   sum1 [`NUM_VOICES / 2];    // pairs
	logic [SW+1:0] sum2 [`NUM_VOICES / 4];    // quads
	logic [SW+2:0] sum3;                      // all eight, fits 16 bits

	// --------------------
	// adder tree
	always_comb begin
		for (int i = 0; i < `NUM_VOICES; i++) begin
			saw[i] = phases[i][`PHASE_W-1 -: SW];   // phase msbs = saw ramp
		end
		for (int i = 0; i < `NUM_VOICES / 2; i++) begin
			sum1[i] = (SW+1)'(saw[2*i]) + (SW+1)'(saw[2*i+1]);
		end
		for (int i = 0; i < `NUM_VOICES / 4; i++) begin
			sum2[i] = (SW+2)'(sum1[2*i]) + (SW+2)'(sum1[2*i+1]);
		end
		sum3 = (SW+3)'(sum2[0]) + (SW+3)'(sum2[1]);
	end

	// output register, cleared so the first i2s word is defined
	always_ff @(posedge clk or posedge trigger) begin
		if (trigger) begin
			mix <= '0;
		end else begin
			mix <= sample_t'(sum3);    // mod 2^16
		end
	end

endmodule

/* hdl/i2s_transmitter.sv */
// PCM5102 i2s transmitter
// word tick divider, 64 tick frame, latches left/right at frame start and
// shifts them msb first with the i2s one bit delay

`include "synth_settings.svh"

module i2s_transmitter (
	input  logic               clk,
	input  logic               trigger,
	input  synth_pkg::sample_t left,
	input  synth_pkg::sample_t right,
	output logic               sample_strobe,    // frame start, one clk
	output logic               bck,
	output logic               lrck,             // low = left
	output logic               din
);
	import synth_pkg::*;

	localparam int WORDS  = `FRAME_CLKS / `I2S_TICK_DIV;   // 64 ticks per frame
	localparam int WORD_W = $clog2(WORDS);
	localparam int TDIV_W = $clog2(`I2S_TICK_DIV);
	localparam int BIT_W  = $clog2(`SAMPLE_W);

	// --------------------
	// tick and word counter

	logic [TDIV_W-1:0] tdiv;
	logic              tick;
	logic [WORD_W-1:0] word;
	logic [WORD_W-1:0] word_nxt;
	logic              frame_start;

	assign tick        = (tdiv == TDIV_W'(`I2S_TICK_DIV - 1));
	assign word_nxt    = WORD_W'(word + 1'b1);
	assign frame_start = tick && (word_nxt == '0);    // wrap to word 0

	// --------------------
	// bit select

	sample_t           l_word;       // latched left
	sample_t           r_word;       // latched right
	logic [WORD_W-3:0] slot;         // bck period inside a half frame
	logic [BIT_W-1:0]  bit_idx;
	logic              din_nxt;

	always_comb begin
		slot    = word_nxt[WORD_W-2:1];
		bit_idx = BIT_W'(`SAMPLE_W - int'(slot));
		if (slot == '0) begin
			// delay slot carries the lsb of the other side's word
			din_nxt = word_nxt[WORD_W-1] ? l_word[0] : r_word[0];
		end else begin
			din_nxt = word_nxt[WORD_W-1] ? r_word[bit_idx] : l_word[bit_idx];
		end
	end

	always_ff @(posedge clk or posedge trigger) begin
		if (trigger) begin
			tdiv          <= '0;
			word          <= '0;
			sample_strobe <= 1'b0;
			bck           <= 1'b0;
			lrck          <= 1'b0;
			din           <= 1'b0;
			l_word        <= '0;
			r_word        <= '0;
		end else begin
			tdiv          <= tick ? '0 : TDIV_W'(tdiv + 1'b1);
			sample_strobe <= frame_start;
			if (tick) begin
				word <= word_nxt;
				bck  <= word_nxt[0];
				lrck <= word_nxt[WORD_W-1];
				if (!word_nxt[0]) begin
					din <= din_nxt;  // only moves when bck falls
				end
			end
			if (frame_start) begin
				l_word <= left;      // old r_word lsb still goes out above
				r_word <= right;
			end
		end
	end

endmodule

/* hdl/synth_top.sv */
// supersaw synth top
// ad7606 in, eight detuned saw voices pitched by channel 5, pcm5102 out
// with the supersaw on the left and channel 1 on the right

`include "synth_settings.svh"

module synth_top (
	input  logic clk,
	input  logic trigger,
	// ad7606
	input  logic db7,
	input  logic db8,
	output logic rdclk,
	output logic conv,
	output logic cs,
	// pcm5102
	output logic bck,
	output logic lrck,
	output logic din
);
	import synth_pkg::*;

	// per voice detune table
	localparam phase_t DETUNES [`NUM_VOICES] = '{
		`DETUNE_0, `DETUNE_1, `DETUNE_2, `DETUNE_3,
		`DETUNE_4, `DETUNE_5, `DETUNE_6, `DETUNE_7
	};

	sample_t channels [`NUM_CH];       // offset binary adc samples
	phase_t  phases [`NUM_VOICES];
	sample_t mix;                      // supersaw output
	logic    sample_strobe;            // audio rate, from the i2s frame

	// --------------------
	// adc
	ad7606_reader u_adc (
		.clk      (clk),
		.trigger  (trigger),
		.db7      (db7),
		.db8      (db8),
		.rdclk    (rdclk),
		.conv     (conv),
		.cs       (cs),
		.channels (channels)
	);

	// --------------------
	// supersaw
	for (genvar i = 0; i < `NUM_VOICES; i++) begin : gen_voice
		saw_voice #(
			.detune (DETUNES[i])
		) u_voice (
			.clk           (clk),
			.trigger       (trigger),
			.sample_strobe (sample_strobe),
			.pitch         (channels[`PITCH_CH]),
			.phase         (phases[i])
		);
	end

	voice_mixer u_mixer (
		.clk     (clk),
		.trigger (trigger),
		.phases  (phases),
		.mix     (mix)
	);

	// --------------------
	// dac
	i2s_transmitter u_dac (
		.clk           (clk),
		.trigger       (trigger),
		.left          (mix),
		.right         (channels[`MONITOR_CH]),  // adc monitor
		.sample_strobe (sample_strobe),
		.bck           (bck),
		.lrck          (lrck),
		.din           (din)
	);

endmodule

/* dv/synth_tb.sv */
// supersaw synth testbench
// feeds the ad7606 serial lines from a stimulus file, decodes the i2s stream
// and checks both words against a supersaw reference model

`include "synth_settings.svh"

module synth_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_ROWS   = 16;
	localparam int MAX_FRAMES = 128;
	localparam int WAIT_LIMIT = 4 * `FRAME_CLKS;       // clk per wait loop
	localparam int BIT_CLKS   = 2 * `ADC_STEP_DIV;     // one adc bit window
	localparam int GROUP_CLKS = 16 * BIT_CLKS;         // one channel pair
	localparam int READ_CLKS  = `FRAME_CLKS / 2;

	localparam logic [31:0] DETUNES [`NUM_VOICES] = '{
		`DETUNE_0, `DETUNE_1, `DETUNE_2, `DETUNE_3,
		`DETUNE_4, `DETUNE_5, `DETUNE_6, `DETUNE_7
	};

	logic clk;
	logic trigger;
	logic db7;
	logic db8;
	wire  rdclk;
	wire  conv;
	wire  cs;
	wire  bck;
	wire  lrck;
	wire  din;

	int          seed = 76729;
	int          errors = 0;
	int          checks = 0;
	int          proto_frames = 0;
	int          proto_errors = 0;
	bit          released = 0;

	// --------------------
	// stimulus table
	string       row_name  [MAX_ROWS];
	int          row_frames[MAX_ROWS];
	logic [15:0] row_raw   [MAX_ROWS][`NUM_CH];
	logic [15:0] row_right [MAX_ROWS];
	int          num_rows;
	int          total_frames;
	int          frame_row [MAX_FRAMES];     // adc frame -> row
	logic [15:0] exp_left  [MAX_FRAMES];     // by i2s frame

	logic [15:0] left_words[$];              // decoded, index = i2s frame
	logic [15:0] right_words[$];

	synth_top DUT (
		.clk     (clk),
		.trigger (trigger),
		.db7     (db7),
		.db8     (db8),
		.rdclk   (rdclk),
		.conv    (conv),
		.cs      (cs),
		.bck     (bck),
		.lrck    (lrck),
		.din     (din)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("ERROR: %s", msg);
		$display("TESTS FAILED");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// --------------------
	// file reader, random rows get fresh values
	task automatic load_stimulus();
		int    fd;
		int    n;
		int    code;
		string line;
		string name;
		int    raw [`NUM_CH];
		int    frames;
		int    exp_r;
		fd = $fopen("dv/synth_stimulus.txt", "r");
		if (fd == 0) abort_run("cannot open dv/synth_stimulus.txt");
		num_rows     = 0;
		total_frames = 0;
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2 || line.substr(0, 0) == "#") continue;
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %d %h", name, raw[0], raw[1],
				raw[2], raw[3], raw[4], raw[5], raw[6], raw[7], frames, exp_r);
			if (n != 11) abort_run("malformed row in stimulus file");
			if (num_rows >= MAX_ROWS || total_frames + frames >= MAX_FRAMES)
				abort_run("stimulus file too long");
			if (name.len() > 4 && name.substr(0, 3) == "rand") begin
				for (int i = 0; i < `NUM_CH; i++) raw[i] = $random(seed) & 16'hffff;
				exp_r = (raw[0] + 16'h8000) & 16'hffff;     // offset binary
			end
			row_name[num_rows]   = name;
			row_frames[num_rows] = frames;
			row_right[num_rows]  = exp_r[15:0];
			for (int i = 0; i < `NUM_CH; i++) row_raw[num_rows][i] = raw[i][15:0];
			for (int k = 0; k < frames; k++) frame_row[total_frames + k] = num_rows;
			total_frames += frames;
			num_rows++;
		end
		$fclose(fd);
	endtask

	// supersaw reference, advance n uses the pitch of adc frame n-1
	task automatic build_model();
		logic [31:0] ph [`NUM_VOICES];
		logic [15:0] pitch;
		logic [15:0] sum;
		for (int v = 0; v < `NUM_VOICES; v++) ph[v] = '0;
		for (int n = 1; n <= total_frames; n++) begin
			sum = '0;
			for (int v = 0; v < `NUM_VOICES; v++) sum += 16'(ph[v][31:32-`SAW_BITS]);
			exp_left[n] = sum;
			pitch = row_raw[frame_row[n-1]][`PITCH_CH] + 16'h8000;
			for (int v = 0; v < `NUM_VOICES; v++)
				ph[v] = ph[v] + ({16'd0, pitch} << `PITCH_SHIFT) + DETUNES[v];
		end
	endtask

	// --------------------
	// ad7606 serial model, bit set two steps ahead of its sample edge
	task automatic drive_adc();
		int          e;
		int          p;
		int          f;
		int          g;
		int          b;
		logic [15:0] a;
		logic [15:0] c;
		e = 0;
		forever begin
			p = e % `FRAME_CLKS;
			f = e / `FRAME_CLKS;
			if (p < READ_CLKS && p % BIT_CLKS == 0) begin
				g = p / GROUP_CLKS;
				b = (p % GROUP_CLKS) / BIT_CLKS;
				a = (f < total_frames) ? row_raw[frame_row[f]][g] : 16'h0;
				c = (f < total_frames) ? row_raw[frame_row[f]][g + 4] : 16'h0;
				db7 <= a[15 - b];    // msb first
				db8 <= c[15 - b];
			end
			@(posedge clk);
			e++;
		end
	endtask

	task automatic wait_words(input int count);
		int waited;
		waited = 0;
		while (right_words.size() < count) begin
			@(posedge clk);
			waited++;
			if (waited > WAIT_LIMIT) abort_run("timeout waiting for an i2s frame");
		end
	endtask

	// --------------------
	// adc protocol monitor and i2s decoder, sampled mid cycle
	initial begin
		logic        last_conv;
		logic        last_rdclk;
		logic        last_bck;
		logic        last_lrck;
		logic [15:0] shift;
		bit          seen_fall;
		int          since;
		int          conv_low;
		int          cs_high;
		int          rd_falls;
		int          e0;
		last_conv  = 1'b1;
		last_rdclk = 1'b1;
		last_bck   = 1'b0;
		last_lrck  = 1'b0;
		shift      = '0;
		seen_fall  = 1'b0;
		since      = 0;
		conv_low   = 0;
		cs_high    = 0;
		rd_falls   = 0;
		forever begin
			@(negedge clk);
			if (released) begin
				if (!conv && last_conv) begin    // frame boundary
					if (seen_fall) begin
						e0 = errors;
						check_value("conv_period", `FRAME_CLKS, since);
						check_value("conv_low_clks", 2, conv_low);
						check_value("cs_high_clks", READ_CLKS, cs_high);
						check_value("rdclk_pulses", 56, rd_falls);
						proto_errors += errors - e0;
						proto_frames++;
					end
					seen_fall = 1'b1;
					since     = 0;
					conv_low  = 0;
					cs_high   = 0;
					rd_falls  = 0;
				end
				since++;
				if (!conv) conv_low++;
				if (cs) cs_high++;
				if (!rdclk && last_rdclk) rd_falls++;
				if (bck && !last_bck) begin
					if (lrck != last_lrck) begin
						// lsb of the word before the lrck edge
						if (last_lrck) right_words.push_back({shift[14:0], din});
						else left_words.push_back({shift[14:0], din});
					end else begin
						shift = {shift[14:0], din};
					end
					last_lrck = lrck;
				end
			end
			last_conv  = conv;
			last_rdclk = rdclk;
			last_bck   = bck;
		end
	end

	// --------------------
	// main sequence
	initial begin
		int f;
		int n;
		int e0;
		trigger = 1'b1;
		db7     = 1'b0;
		db8     = 1'b0;
		load_stimulus();
		build_model();
		repeat (9) @(posedge clk);
		@(negedge clk);
		check_value("rdclk", 1, rdclk);     // reset state
		check_value("conv", 1, conv);
		check_value("cs", 0, cs);
		check_value("bck", 0, bck);
		check_value("lrck", 0, lrck);
		check_value("din", 0, din);
		$display("test reset_state: %s", (errors == 0) ? "ok" : "failed");
		@(posedge clk);
		trigger <= 1'b0;
		released = 1'b1;
		fork
			drive_adc();
		join_none
		f = 0;
		for (int r = 0; r < num_rows; r++) begin
			e0 = errors;
			for (int k = 0; k < row_frames[r]; k++) begin
				n = f + 1;                     // i2s frame carrying adc frame f
				wait_words(n + 1);
				check_value("left_word", exp_left[n], left_words[n]);
				check_value("right_word", row_right[r], right_words[n]);
				f++;
			end
			$display("test %s: %s, %0d frames", row_name[r],
				(errors == e0) ? "ok" : "failed", row_frames[r]);
		end
		if (proto_frames == 0) begin
			errors++;
			$display("no complete adc frame was observed");
		end
		$display("test adc_protocol: %s, %0d frames", (proto_errors == 0) ? "ok" : "failed",
			proto_frames);
		$display("checks %0d, errors %0d, frames %0d", checks, errors, total_frames);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* dv/synth_stimulus.txt */
# name ch1 ch2 ch3 ch4 ch5 ch6 ch7 ch8 (raw hex) frames expected_right (hex)
# rows named rand* get values from the seeded generator
zero_inputs  0000 0000 0000 0000 0000 0000 0000 0000 3 8000
ch1_positive 1234 0001 0002 0003 0100 0005 0006 0007 3 9234
ch1_negative f000 1111 2222 3333 0200 5555 6666 7777 3 7000
ch1_max      7fff 0000 ffff 0000 8000 ffff 0000 ffff 2 ffff
ch1_min      8000 ffff 0000 ffff 7fff 0000 ffff 0000 2 0000
pitch_step   0abc 0000 0000 0000 0400 0000 0000 0000 2 8abc
pitch_low    0abc 0000 0000 0000 ff00 0000 0000 0000 2 8abc
lane_mix     a5a5 5a5a 3c3c c3c3 1111 2222 4444 8888 2 25a5
rand_a       0000 0000 0000 0000 0000 0000 0000 0000 3 0000
rand_b       0000 0000 0000 0000 0000 0000 0000 0000 2 0000
rand_c       0000 0000 0000 0000 0000 0000 0000 0000 2 0000

/* tb.f */
+incdir+hdl
hdl/synth_pkg.sv
hdl/ad7606_reader.sv
hdl/saw_voice.sv
hdl/voice_mixer.sv
hdl/i2s_transmitter.sv
hdl/synth_top.sv
dv/synth_tb.sv

/* Makefile */
# Verilator build for the supersaw synth testbench

VERILATOR ?= verilator
TOP       ?= synth_tb
RTL_TOP   ?= synth_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wno-fatal
PASS_MSG  ?= TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -Ihdl hdl/synth_pkg.sv hdl/ad7606_reader.sv \
		hdl/saw_voice.sv hdl/voice_mixer.sv hdl/i2s_transmitter.sv hdl/synth_top.sv \
		--top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
